/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OP_R      = 7'b0110011, // Register-register ALU
		OP_IMM    = 7'b0010011, // Register-immediate ALU
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_LUI    = 7'b0110111
	} opcode_e;

	// Immediate layouts in the instruction word
	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_S = 2'd1,
		IMM_B = 2'd2,
		IMM_U = 2'd3
	} imm_fmt_e;

	// funct3 for ALU operations
	localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA share this
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct3 for branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	localparam logic [6:0] F7_ALT = 7'b0100000; // Selects SUB or SRA

endpackage

`default_nettype wire

/* rv_alu_pkg.sv */
`default_nettype none

package rv_alu_pkg;

	// Coarse operation class chosen by the main decoder
	typedef enum logic [1:0] {
		CLS_ADD    = 2'd0, // Address computation for loads and stores
		CLS_BRANCH = 2'd1, // Subtract for the compare
		CLS_FUNCT  = 2'd2, // Operation taken from funct3 and funct7
		CLS_PASS_B = 2'd3  // LUI
	} alu_class_e;

	// Operation actually performed by the ALU
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_SLT    = 4'd8,
		ALU_SLTU   = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_ctrl_e;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [31:0]          inst,
	input  rv_isa_pkg::imm_fmt_e imm_fmt,
	output rv_isa_pkg::opcode_e  opcode,
	output logic [4:0]           rs1,
	output logic [4:0]           rs2,
	output logic [4:0]           rd,
	output logic [2:0]           funct3,
	output logic [6:0]           funct7,
	output logic [31:0]          imm
);
	import rv_isa_pkg::*;

	// Fixed field positions
	assign opcode = opcode_e'(inst[6:0]);
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	// Immediate bits are scattered differently per format, sign always in bit 31
	always_comb begin
		case (imm_fmt)
			IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
			IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			IMM_U: imm = {inst[31:12], 12'b0};
			default: imm = '0;
		endcase
	end

	// Stimulus outside the supported subset would leave every enable low
	a_opcode_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		opcode inside {OP_R, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_LUI}
	) else $error("Unsupported opcode %b", inst[6:0]);

endmodule

`default_nettype wire

/* main_control.sv */
`timescale 1ns/1ps
`default_nettype none

module main_control (
	input  rv_isa_pkg::opcode_e    opcode,
	output logic                   reg_write,
	output logic                   mem_write,
	output logic                   alu_src_imm,
	output logic                   wb_from_mem,
	output logic                   branch,
	output rv_alu_pkg::alu_class_e alu_class,
	output rv_isa_pkg::imm_fmt_e   imm_fmt
);
	import rv_isa_pkg::*;
	import rv_alu_pkg::*;

	always_comb begin
		reg_write   = 1'b0; // Unknown opcodes change no state
		mem_write   = 1'b0;
		alu_src_imm = 1'b0;
		wb_from_mem = 1'b0;
		branch      = 1'b0;
		alu_class   = CLS_ADD;
		imm_fmt     = IMM_I;
		case (opcode)
			OP_R: begin
				reg_write = 1'b1;
				alu_class = CLS_FUNCT;
			end
			OP_IMM: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_class   = CLS_FUNCT;
			end
			OP_LOAD: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1; // rs1 + offset
				wb_from_mem = 1'b1;
			end
			OP_STORE: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm_fmt     = IMM_S;
			end
			OP_BRANCH: begin
				branch    = 1'b1; // Compare rs1 with rs2, offset goes to pc_unit
				alu_class = CLS_BRANCH;
				imm_fmt   = IMM_B;
			end
			OP_LUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_class   = CLS_PASS_B;
				imm_fmt     = IMM_U;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* alu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_control (
	input  rv_alu_pkg::alu_class_e alu_class,
	input  logic [2:0]             funct3,
	input  logic [6:0]             funct7,
	input  logic                   alu_src_imm,
	output rv_alu_pkg::alu_ctrl_e  alu_ctrl
);
	import rv_isa_pkg::*;
	import rv_alu_pkg::*;

	logic alt; // funct7 asks for the alternate operation

	assign alt = (funct7 == F7_ALT);

	always_comb begin
		case (alu_class)
			CLS_ADD:    alu_ctrl = ALU_ADD;
			CLS_BRANCH: alu_ctrl = ALU_SUB;
			CLS_PASS_B: alu_ctrl = ALU_PASS_B;
			default: begin
				case (funct3)
					// ADDI has no SUB form, bit 30 there is immediate data
					F3_ADD:  alu_ctrl = (alt && !alu_src_imm) ? ALU_SUB : ALU_ADD;
					F3_SLL:  alu_ctrl = ALU_SLL;
					F3_SLT:  alu_ctrl = ALU_SLT;
					F3_SLTU: alu_ctrl = ALU_SLTU;
					F3_XOR:  alu_ctrl = ALU_XOR;
					F3_SR:   alu_ctrl = alt ? ALU_SRA : ALU_SRL; // SRAI keeps funct7 too
					F3_OR:   alu_ctrl = ALU_OR;
					default: alu_ctrl = ALU_AND;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu #(
	parameter int XLEN = 32
) (
	input  rv_alu_pkg::alu_ctrl_e alu_ctrl,
	input  logic [XLEN-1:0]       a,
	input  logic [XLEN-1:0]       b,
	output logic [XLEN-1:0]       result,
	output logic                  zero,
	output logic                  carry,
	output logic                  less,
	output logic                  overflow
);
	import rv_alu_pkg::*;

	localparam int SHW = $clog2(XLEN); // Shift amount width

	logic [XLEN:0]   sum_ext; // Sum with carry out on top
	logic [XLEN-1:0] diff;
	logic [SHW-1:0]  shamt;
	logic            ovf_add;
	logic            ovf_sub;

	assign sum_ext = {1'b0, a} + {1'b0, b};
	assign diff    = a - b;
	assign shamt   = b[SHW-1:0];

	// Signed overflow: operands agree in sign but the result does not
	assign ovf_add = (a[XLEN-1] == b[XLEN-1]) && (sum_ext[XLEN-1] != a[XLEN-1]);
	assign ovf_sub = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);

	assign less     = diff[XLEN-1] ^ ovf_sub; // Signed a < b
	assign carry    = sum_ext[XLEN];
	assign overflow = (alu_ctrl == ALU_SUB) ? ovf_sub : ovf_add;
	assign zero     = (result == '0);

	always_comb begin
		case (alu_ctrl)
			ALU_ADD:    result = sum_ext[XLEN-1:0];
			ALU_SUB:    result = diff;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_SLL:    result = a << shamt;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $signed(a) >>> shamt;
			ALU_SLT:    result = {{(XLEN-1){1'b0}}, less};
			ALU_SLTU:   result = {{(XLEN-1){1'b0}}, (a < b)};
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            we,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin // x0 is never written
			regs[rd] <= wdata;
		end
	end

	// Asynchronous read
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// Both read ports see zero for x0 whatever was written to rd 0
	a_x0_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(rs1 != 5'd0 || rs1_data == '0) && (rs2 != 5'd0 || rs2_data == '0)
	) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
	parameter int XLEN       = 32,
	parameter int DMEM_WORDS = 128
) (
	input  logic            clk,
	input  logic            we,
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0] mem [DMEM_WORDS];
	logic [AW-1:0]   word_idx;

	assign word_idx = addr[AW+1:2]; // Byte address to word index

	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_idx] <= wdata;
		end
	end

	assign rdata = mem[word_idx]; // Combinational read for LW

	// Store address comes from the ALU, so check it against the memory shape
	a_store_addr: assert property (
		@(posedge clk)
		we |-> (addr[1:0] == 2'b00) && ((addr >> 2) < DMEM_WORDS)
	) else $error("Bad store address %h", addr);

endmodule

`default_nettype wire

/* pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
	parameter int XLEN = 32
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            branch,
	input  logic            zero,
	input  logic [2:0]      funct3,
	input  logic [XLEN-1:0] imm,
	output logic [XLEN-1:0] pc
);
	import rv_isa_pkg::*;

	logic            taken;
	logic [XLEN-1:0] pc_next;

	// Zero flag comes from rs1 - rs2
	assign taken = branch && (((funct3 == F3_BEQ) && zero) || ((funct3 == F3_BNE) && !zero));

	assign pc_next = taken ? (pc + imm) : (pc + XLEN'(4));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
	parameter int XLEN       = 32,
	parameter int DMEM_WORDS = 128
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic [31:0]     inst,
	output logic [XLEN-1:0] alu_out,
	output logic [XLEN-1:0] pc_out,
	output logic            alu_zero
);
	import rv_isa_pkg::*;
	import rv_alu_pkg::*;

	// Decoded fields
	opcode_e         opcode;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [31:0]     imm;

	// Control levels
	logic            reg_write;
	logic            mem_write;
	logic            alu_src_imm;
	logic            wb_from_mem;
	logic            branch;
	alu_class_e      alu_class;
	imm_fmt_e        imm_fmt;
	alu_ctrl_e       alu_ctrl;

	// Datapath
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] mem_rdata;
	logic [XLEN-1:0] wb_data;

	instr_decoder u_decoder (
		.clk     (clk),
		.arst_n  (arst_n),
		.inst    (inst),
		.imm_fmt (imm_fmt),
		.opcode  (opcode),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.funct3  (funct3),
		.funct7  (funct7),
		.imm     (imm)
	);

	main_control u_control (
		.opcode      (opcode),
		.reg_write   (reg_write),
		.mem_write   (mem_write),
		.alu_src_imm (alu_src_imm),
		.wb_from_mem (wb_from_mem),
		.branch      (branch),
		.alu_class   (alu_class),
		.imm_fmt     (imm_fmt)
	);

	alu_control u_alu_control (
		.alu_class   (alu_class),
		.funct3      (funct3),
		.funct7      (funct7),
		.alu_src_imm (alu_src_imm),
		.alu_ctrl    (alu_ctrl)
	);

	reg_file #(.XLEN(XLEN)) u_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.we       (reg_write),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.wdata    (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	assign alu_b = alu_src_imm ? imm : rs2_data; // Operand B select

	alu #(.XLEN(XLEN)) u_alu (
		.alu_ctrl (alu_ctrl),
		.a        (rs1_data),
		.b        (alu_b),
		.result   (alu_out),
		.zero     (alu_zero),
		.carry    (), // No flag register in this core
		.less     (),
		.overflow ()
	);

	data_mem #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) u_data_mem (
		.clk   (clk),
		.we    (mem_write),
		.addr  (alu_out),
		.wdata (rs2_data),
		.rdata (mem_rdata)
	);

	assign wb_data = wb_from_mem ? mem_rdata : alu_out; // Write-back select

	pc_unit #(.XLEN(XLEN)) u_pc (
		.clk    (clk),
		.arst_n (arst_n),
		.branch (branch),
		.zero   (alu_zero),
		.funct3 (funct3),
		.imm    (imm),
		.pc     (pc_out)
	);

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
	import rv_isa_pkg::*;

	localparam int          XLEN       = 32;
	localparam int          DMEM_WORDS = 128;
	localparam logic [31:0] NOP        = 32'h0000_0013; // ADDI x0, x0, 0

	logic            clk;
	logic            arst_n;
	logic [31:0]     inst;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] pc_out;
	logic            alu_zero;

	logic [31:0] model_regs [32];
	logic [31:0] model_mem [DMEM_WORDS];
	logic [31:0] model_pc;
	logic        checking;
	string       test_name;
	integer      seed;
	int          checks;
	int          data_errors;
	int          flag_errors;
	int          timeout_errors;

	rv_core #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.inst     (inst),
		.alu_out  (alu_out),
		.pc_out   (pc_out),
		.alu_zero (alu_zero)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#50000;
		$display("Simulation did not finish within 50000 ns");
		$display("Testbench failed");
		$finish;
	end

	// Expected ALU result, zero flag, next pc and write-back from the RV32I rules
	function automatic void ref_model(
		input  logic [31:0] ins,
		output logic [31:0] exp_alu,
		output logic        exp_zero,
		output logic [31:0] exp_pc,
		output logic        exp_reg_we,
		output logic [31:0] exp_wb
	);
		logic [6:0]         op;
		logic [2:0]         f3;
		logic [6:0]         f7;
		logic [31:0]        a;
		logic [31:0]        b;
		logic signed [31:0] sa;
		logic [31:0]        imm_i;
		logic [31:0]        imm_s;
		logic [31:0]        imm_b;
		logic               taken;
		op    = ins[6:0];
		f3    = ins[14:12];
		f7    = ins[31:25];
		a     = model_regs[ins[19:15]];
		b     = model_regs[ins[24:20]];
		sa    = a;
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		exp_alu    = 32'd0;
		exp_reg_we = 1'b0;
		taken      = 1'b0;
		if (op == OP_IMM)
			b = imm_i;
		case (op)
			OP_R, OP_IMM: begin
				exp_reg_we = 1'b1;
				case (f3)
					F3_ADD:  exp_alu = (op == OP_R && f7 == F7_ALT) ? a - b : a + b;
					F3_SLL:  exp_alu = a << b[4:0];
					F3_SLT:  exp_alu = {31'b0, $signed(a) < $signed(b)};
					F3_SLTU: exp_alu = {31'b0, a < b};
					F3_XOR:  exp_alu = a ^ b;
					F3_SR: begin
						if (f7 == F7_ALT)
							exp_alu = sa >>> b[4:0]; // Arithmetic keeps the sign
						else
							exp_alu = a >> b[4:0];
					end
					F3_OR:   exp_alu = a | b;
					default: exp_alu = a & b;
				endcase
			end
			OP_LOAD: begin
				exp_alu    = a + imm_i;
				exp_reg_we = 1'b1;
			end
			OP_STORE: exp_alu = a + imm_s;
			OP_BRANCH: begin
				exp_alu = a - b;
				taken   = (f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b);
			end
			OP_LUI: begin
				exp_alu    = {ins[31:12], 12'b0};
				exp_reg_we = 1'b1;
			end
			default: ;
		endcase
		exp_zero = (exp_alu == 32'd0);
		exp_pc   = taken ? model_pc + imm_b : model_pc + 32'd4;
		exp_wb   = (op == OP_LOAD) ? model_mem[exp_alu[8:2]] : exp_alu;
	endfunction

	// Model state follows the DUT at each rising edge
	always @(posedge clk) begin : update_model
		logic [31:0] alu_e;
		logic [31:0] pc_e;
		logic [31:0] wb_e;
		logic        zero_e;
		logic        we_e;
		if (arst_n) begin
			ref_model(inst, alu_e, zero_e, pc_e, we_e, wb_e);
			if (inst[6:0] == OP_STORE)
				model_mem[alu_e[8:2]] = model_regs[inst[24:20]];
			if (we_e && inst[11:7] != 5'd0)
				model_regs[inst[11:7]] = wb_e;
			model_pc = pc_e;
		end else begin
			for (int i = 0; i < 32; i++)
				model_regs[i] = 32'd0;
			model_pc = 32'd0;
		end
	end

	task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			data_errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			flag_errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	// Outputs are stable one ns after the falling edge that drove inst
	initial begin : compare_outputs
		logic [31:0] alu_e;
		logic [31:0] pc_e;
		logic [31:0] wb_e;
		logic        zero_e;
		logic        we_e;
		forever begin
			@(negedge clk);
			#1;
			if (checking) begin
				ref_model(inst, alu_e, zero_e, pc_e, we_e, wb_e);
				check_data("alu_out", alu_e, alu_out);
				check_flag("alu_zero", zero_e, alu_zero);
				check_data("pc_out", model_pc, pc_out);
			end
		end
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $random(seed);
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0]; // Never x0
	endfunction

	task automatic run_inst(input logic [31:0] ins);
		@(negedge clk);
		inst = ins;
	endtask

	// LUI plus ADDI with the upper part rounded for the sign-extended low part
	task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		run_inst(u_type(upper[31:12], rd));
		run_inst(i_type(OP_IMM, value[11:0], rd, F3_ADD, rd));
	endtask

	task automatic wait_pc(input logic [31:0] target, input int limit);
		int n;
		n = 0;
		while (pc_out !== target && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (pc_out !== target) begin
			timeout_errors++;
			$display("Timeout: pc_out did not reach %h within %0d cycles", target, limit);
		end
	endtask

	initial begin : main_sequence
		logic [4:0]  src;
		logic [4:0]  src2;
		logic [4:0]  dst;
		logic [31:0] rnd;
		logic [11:0] imm;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [6:0]  idx;
		logic [6:0]  idx_q [$];
		logic [31:0] final_pc;
		arst_n         = 1'b0;
		inst           = NOP;
		checking       = 1'b0;
		seed           = 32'h57da_a04f;
		checks         = 0;
		data_errors    = 0;
		flag_errors    = 0;
		timeout_errors = 0;
		model_pc       = 32'd0;
		test_name      = "reset";
		repeat (8) @(posedge clk);
		@(negedge clk);
		wait_pc(32'd0, 4);
		arst_n   = 1'b1;
		checking = 1'b1;
		check_data("pc_out", 32'd0, pc_out);
		repeat (3) run_inst(NOP);

		test_name = "imm_ops";
		repeat (4) begin
			src = pick_reg();
			set_reg(src, $random(seed));
			for (int k = 0; k < 9; k++) begin
				rnd = $random(seed);
				dst = pick_reg();
				imm = rnd[11:0];
				case (k)
					0: f3 = F3_ADD;
					1: f3 = F3_AND;
					2: f3 = F3_OR;
					3: f3 = F3_XOR;
					4: f3 = F3_SLT;
					5: f3 = F3_SLTU;
					6: f3 = F3_SLL;
					default: f3 = F3_SR;
				endcase
				if (k >= 6)
					imm = {(k == 8) ? F7_ALT : 7'b0, rnd[4:0]}; // SLLI, SRLI, SRAI
				run_inst(i_type(OP_IMM, imm, src, f3, dst));
			end
		end

		test_name = "reg_ops";
		repeat (4) begin
			src  = pick_reg();
			src2 = pick_reg();
			set_reg(src, $random(seed));
			set_reg(src2, $random(seed));
			for (int k = 0; k < 10; k++) begin
				f7 = (k == 1 || k == 9) ? F7_ALT : 7'b0; // SUB and SRA
				f3 = (k == 0 || k == 1) ? F3_ADD : 3'(k - 1);
				if (k == 9)
					f3 = F3_SR;
				run_inst(r_type(f7, src2, src, f3, pick_reg()));
			end
		end
		set_reg(5'd1, 32'hffff_fffb); // Negative against positive
		set_reg(5'd2, 32'd3);
		run_inst(r_type(7'b0, 5'd2, 5'd1, F3_SLT, 5'd3));
		run_inst(r_type(7'b0, 5'd2, 5'd1, F3_SLTU, 5'd3));
		run_inst(r_type(7'b0, 5'd1, 5'd2, F3_SLT, 5'd3));
		run_inst(r_type(7'b0, 5'd1, 5'd2, F3_SLTU, 5'd3));
		run_inst(r_type(F7_ALT, 5'd2, 5'd1, F3_SR, 5'd3));

		test_name = "x0";
		set_reg(5'd7, $random(seed));
		run_inst(i_type(OP_IMM, 12'h123, 5'd0, F3_ADD, 5'd0));
		run_inst(r_type(7'b0, 5'd7, 5'd7, F3_ADD, 5'd0));
		run_inst(r_type(7'b0, 5'd7, 5'd0, F3_ADD, 5'd5));
		run_inst(r_type(7'b0, 5'd0, 5'd7, F3_ADD, 5'd6));

		test_name = "memory";
		repeat (6) begin
			rnd = $random(seed);
			idx = rnd[6:0];
			idx_q.push_back(idx);
			src = pick_reg();
			set_reg(src, $random(seed));
			run_inst(s_type({3'b0, idx, 2'b00}, src, 5'd0));
		end
		while (idx_q.size() > 0) begin
			idx = idx_q.pop_front();
			dst = pick_reg();
			run_inst(i_type(OP_LOAD, {3'b0, idx, 2'b00}, 5'd0, 3'b010, dst));
			run_inst(r_type(7'b0, 5'd0, dst, F3_ADD, pick_reg()));
		end

		test_name = "branch";
		rnd = $random(seed);
		set_reg(5'd1, rnd);
		set_reg(5'd2, rnd);
		set_reg(5'd3, rnd ^ 32'd1);
		run_inst(b_type(13'd16, 5'd2, 5'd1, F3_BEQ)); // Taken
		run_inst(b_type(13'd16, 5'd3, 5'd1, F3_BEQ));
		run_inst(b_type(-13'sd8, 5'd3, 5'd1, F3_BNE)); // Taken backwards
		run_inst(b_type(13'd12, 5'd2, 5'd1, F3_BNE));
		run_inst(b_type(13'd20, 5'd0, 5'd0, F3_BEQ));
		repeat (4) begin
			rnd = $random(seed);
			f3 = rnd[13] ? F3_BNE : F3_BEQ;
			run_inst(b_type({rnd[12:1], 1'b0}, rnd[14] ? 5'd3 : 5'd2, 5'd1, f3));
		end

		run_inst(NOP);
		final_pc = model_pc + 32'd4;
		wait_pc(final_pc, 8);
		#2;
		checking = 1'b0;
		$display("Checks %0d, data errors %0d, flag errors %0d, timeouts %0d",
			checks, data_errors, flag_errors, timeout_errors);
		if (data_errors + flag_errors + timeout_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rv_isa_pkg.sv
rv_alu_pkg.sv
instr_decoder.sv
main_control.sv
alu_control.sv
alu.sv
reg_file.sv
data_mem.sv
pc_unit.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
# Verilator build and run for the RV32I core slice

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed
SRCS      := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
